/* src/note_pkg.sv */
package note_pkg;

    //------------------------------------------------------------------------
    // Data types

    typedef logic signed [23:0] mic_t;       // Raw microphone sample
    typedef logic signed [15:0] sample_t;    // Upper mic bits, sound output
    typedef logic        [ 7:0] seg_t;       // Segments in abcdefgh order
    typedef logic        [ 3:0] note_idx_t;  // 0 none, 1..12 C..B
    typedef logic        [ 8:0] period_t;    // Counted in sample ticks
    typedef logic        [15:0] div_t;       // Clocks per sample tick
    typedef logic        [ 7:0] apb_addr_t;
    typedef logic        [31:0] apb_data_t;

    //------------------------------------------------------------------------
    // Register map and reset values

    localparam apb_addr_t ADDR_CTRL   = 8'h00;  // bit 0 enable, bits 3:1 volume
    localparam apb_addr_t ADDR_DIV    = 8'h04;
    localparam apb_addr_t ADDR_THRESH = 8'h08;
    localparam apb_addr_t ADDR_STATUS = 8'h0C;  // Read only

    localparam div_t       DIV_RESET    = 16'd1042;  // About 48 kHz at 50 MHz
    localparam sample_t    THRESH_RESET = 16'sd256;
    localparam logic [2:0] VOLUME_RESET = 3'd0;

    //------------------------------------------------------------------------
    // Note tables, entry 0 is C4 and entry 11 is B4

    localparam int      NUM_NOTES    = 12;
    localparam period_t NOTE_TIMEOUT = 9'd256;  // Ticks without a crossing

    // Full periods accepted for each note, split at the midpoints
    localparam period_t NOTE_PERIOD_MIN [NUM_NOTES] = '{
        9'd179, 9'd169, 9'd159, 9'd150, 9'd142, 9'd134,
        9'd127, 9'd120, 9'd113, 9'd106, 9'd100, 9'd94
    };

    localparam period_t NOTE_PERIOD_MAX [NUM_NOTES] = '{
        9'd190, 9'd178, 9'd168, 9'd158, 9'd149, 9'd141,
        9'd133, 9'd126, 9'd119, 9'd112, 9'd105, 9'd99
    };

    localparam period_t NOTE_HALF_PERIOD [NUM_NOTES] = '{
        9'd92, 9'd86, 9'd82, 9'd77, 9'd73, 9'd69,
        9'd65, 9'd61, 9'd58, 9'd54, 9'd51, 9'd48
    };

    localparam seg_t NOTE_SEG [NUM_NOTES] = '{
        8'b10011100,  // C
        8'b10011101,  // C#
        8'b01111010,  // D
        8'b01111011,  // D#
        8'b10011110,  // E
        8'b10001110,  // F
        8'b10001111,  // F#
        8'b10111100,  // G
        8'b10111101,  // G#
        8'b11101110,  // A
        8'b11101111,  // A#
        8'b00111110   // B
    };

    localparam seg_t       SEG_BLANK = 8'b00000000;
    localparam logic [7:0] DIGIT_ON  = 8'b00000001;  // Only digit 0 is lit
    localparam sample_t    SOUND_MAX = 16'sd32767;   // Full-scale amplitude

endpackage

/* src/lab_control.sv */
`timescale 1ns/1ps

module lab_control
    import note_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output logic       pslverr,

    input  note_idx_t  note_idx,

    output logic       sample_tick,
    output logic       synth_en,
    output logic [2:0] volume,
    output sample_t    thresh
);

    //------------------------------------------------------------------------
    // APB decode

    div_t div;
    div_t tick_cnt;
    logic access;
    logic mapped;
    logic wr_ok;

    assign access = psel && penable;  // Second cycle of a transfer
    assign pready = 1'b1;             // No wait states

    assign mapped = (paddr == ADDR_CTRL)   || (paddr == ADDR_DIV)
                 || (paddr == ADDR_THRESH) || (paddr == ADDR_STATUS);

    assign pslverr = access && (!mapped || (pwrite && paddr == ADDR_STATUS));
    assign wr_ok   = access && pwrite && !pslverr;

    always_comb begin
        case (paddr)
            ADDR_CTRL:   prdata = apb_data_t'({volume, synth_en});
            ADDR_DIV:    prdata = apb_data_t'(div);
            ADDR_THRESH: prdata = apb_data_t'({16'b0, thresh});
            ADDR_STATUS: prdata = apb_data_t'(note_idx);
            default:     prdata = '0;
        endcase
    end

    //------------------------------------------------------------------------
    // Registers

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            synth_en <= 1'b0;
            volume   <= VOLUME_RESET;
            div      <= DIV_RESET;
            thresh   <= THRESH_RESET;
        end else if (wr_ok) begin
            case (paddr)
                ADDR_CTRL: begin
                    synth_en <= pwdata[0];
                    volume   <= pwdata[3:1];
                end
                ADDR_DIV:    div    <= (pwdata[15:0] == '0) ? div_t'(1) : pwdata[15:0];
                ADDR_THRESH: thresh <= pwdata[15:0];
                default:     ;  // STATUS and holes never get here
            endcase
        end
    end

    //------------------------------------------------------------------------
    // Sample tick divider

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt    <= DIV_RESET;
            sample_tick <= 1'b0;
        end else if (tick_cnt <= div_t'(1) || tick_cnt > div) begin  // Smaller div acts at once
            tick_cnt    <= div;
            sample_tick <= 1'b1;
        end else begin
            tick_cnt    <= tick_cnt - div_t'(1);
            sample_tick <= 1'b0;
        end
    end

endmodule

/* src/note_recognizer.sv */
`timescale 1ns/1ps

module note_recognizer
    import note_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sample_tick,
    input  mic_t    mic,
    input  sample_t thresh,
    output seg_t    note_seg
);

    typedef enum logic {
        WAIT_LOW,   // Waiting for a sample below -thresh
        WAIT_HIGH   // Armed, waiting for a sample above +thresh
    } state_t;

    state_t    state;
    sample_t   sample;
    sample_t   neg_thresh;
    logic      rise;
    period_t   tick_cnt;    // Ticks since the last rising crossing
    period_t   period;
    note_idx_t cur_idx;
    note_idx_t prev_idx;

    //------------------------------------------------------------------------
    // Period to note lookup

    function automatic note_idx_t period_to_note(input period_t p);
        note_idx_t idx;
        idx = '0;
        for (int i = 0; i < NUM_NOTES; i++) begin
            if (p >= NOTE_PERIOD_MIN[i] && p <= NOTE_PERIOD_MAX[i])
                idx = note_idx_t'(i + 1);
        end
        return idx;
    endfunction

    function automatic seg_t note_to_seg(input note_idx_t idx);
        seg_t seg;
        seg = SEG_BLANK;
        for (int i = 0; i < NUM_NOTES; i++) begin
            if (idx == note_idx_t'(i + 1))
                seg = NOTE_SEG[i];
        end
        return seg;
    endfunction

    //------------------------------------------------------------------------
    // Hysteresis zero-crossing detector

    assign sample     = mic[23:8];  // Drop the low byte
    assign neg_thresh = -thresh;
    assign rise       = sample_tick && (state == WAIT_HIGH) && (sample > thresh);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WAIT_LOW;
        end else if (sample_tick) begin
            case (state)
                WAIT_LOW:  if (sample < neg_thresh) state <= WAIT_HIGH;
                WAIT_HIGH: if (sample > thresh)     state <= WAIT_LOW;
                default:   state <= WAIT_LOW;
            endcase
        end
    end

    //------------------------------------------------------------------------
    // Period meter and note decision

    assign period  = tick_cnt + period_t'(1);  // Counts the crossing tick too
    assign cur_idx = period_to_note(period);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            prev_idx <= '0;
            note_seg <= SEG_BLANK;
        end else if (rise) begin
            tick_cnt <= '0;
            prev_idx <= cur_idx;
            if (cur_idx == prev_idx)  // Two periods agree, none included
                note_seg <= note_to_seg(cur_idx);
        end else if (sample_tick && tick_cnt != NOTE_TIMEOUT) begin
            tick_cnt <= period;  // Saturates at the timeout
            if (period == NOTE_TIMEOUT) begin
                note_seg <= SEG_BLANK;  // Silence
                prev_idx <= '0;
            end
        end
    end

endmodule

/* src/note_synthesizer.sv */
`timescale 1ns/1ps

module note_synthesizer
    import note_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sample_tick,
    input  seg_t       note_seg,
    input  logic       synth_en,
    input  logic [2:0] volume,
    output note_idx_t  note_idx,
    output sample_t    sound,
    output seg_t       abcdefgh,
    output logic [7:0] digit
);

    logic    active;
    logic    polarity;
    period_t half_cnt;
    period_t half_len;
    sample_t amp;

    //------------------------------------------------------------------------
    // Pattern to note index

    always_comb begin
        case (note_seg)
            NOTE_SEG[0]:  note_idx = 4'd1;   // C
            NOTE_SEG[1]:  note_idx = 4'd2;   // C#
            NOTE_SEG[2]:  note_idx = 4'd3;   // D
            NOTE_SEG[3]:  note_idx = 4'd4;   // D#
            NOTE_SEG[4]:  note_idx = 4'd5;   // E
            NOTE_SEG[5]:  note_idx = 4'd6;   // F
            NOTE_SEG[6]:  note_idx = 4'd7;   // F#
            NOTE_SEG[7]:  note_idx = 4'd8;   // G
            NOTE_SEG[8]:  note_idx = 4'd9;   // G#
            NOTE_SEG[9]:  note_idx = 4'd10;  // A
            NOTE_SEG[10]: note_idx = 4'd11;  // A#
            NOTE_SEG[11]: note_idx = 4'd12;  // B
            default:      note_idx = 4'd0;   // Blank or unknown
        endcase
    end

    always_comb begin
        half_len = NOTE_HALF_PERIOD[0];
        for (int i = 0; i < NUM_NOTES; i++) begin
            if (note_idx == note_idx_t'(i + 1))
                half_len = NOTE_HALF_PERIOD[i];
        end
    end

    //------------------------------------------------------------------------
    // Square-wave generator

    assign active = synth_en && (note_idx != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            half_cnt <= '0;
            polarity <= 1'b0;
        end else if (sample_tick && active) begin
            if (half_cnt >= half_len - period_t'(1)) begin  // Also catches a shorter new note
                half_cnt <= '0;
                polarity <= ~polarity;
            end else begin
                half_cnt <= half_cnt + period_t'(1);
            end
        end
    end

    assign amp   = SOUND_MAX >>> volume;
    assign sound = !active ? '0 : (polarity ? -amp : amp);

    //------------------------------------------------------------------------
    // Display, digit 0 only

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            abcdefgh <= SEG_BLANK;
            digit    <= '0;
        end else begin
            abcdefgh <= note_seg;
            digit    <= (note_idx != '0) ? DIGIT_ON : '0;
        end
    end

endmodule

/* src/note_lab_top.sv */
`timescale 1ns/1ps

module note_lab_top
    import note_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output logic       pslverr,

    input  mic_t       mic,
    output sample_t    sound,
    output seg_t       abcdefgh,
    output logic [7:0] digit
);

    //------------------------------------------------------------------------

    logic       sample_tick;  // Shared by both halves
    logic       synth_en;
    logic [2:0] volume;
    sample_t    thresh;
    seg_t       note_seg;     // Recognizer result as a segment pattern
    note_idx_t  note_idx;

    //------------------------------------------------------------------------

    lab_control u_lab_control (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .psel        ( psel        ),
        .penable     ( penable     ),
        .pwrite      ( pwrite      ),
        .paddr       ( paddr       ),
        .pwdata      ( pwdata      ),
        .prdata      ( prdata      ),
        .pready      ( pready      ),
        .pslverr     ( pslverr     ),
        .note_idx    ( note_idx    ),
        .sample_tick ( sample_tick ),
        .synth_en    ( synth_en    ),
        .volume      ( volume      ),
        .thresh      ( thresh      )
    );

    note_recognizer u_note_recognizer (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .sample_tick ( sample_tick ),
        .mic         ( mic         ),
        .thresh      ( thresh      ),
        .note_seg    ( note_seg    )
    );

    note_synthesizer u_note_synthesizer (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .sample_tick ( sample_tick ),
        .note_seg    ( note_seg    ),
        .synth_en    ( synth_en    ),
        .volume      ( volume      ),
        .note_idx    ( note_idx    ),
        .sound       ( sound       ),
        .abcdefgh    ( abcdefgh    ),
        .digit       ( digit       )
    );

endmodule

/* verification/note_lab_properties.sv */
`timescale 1ns/1ps

module note_lab_properties
    import note_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       psel,
    input logic       penable,
    input logic       pready,
    input logic       pslverr,
    input logic       synth_en,
    input sample_t    sound,
    input seg_t       abcdefgh,
    input logic [7:0] digit
);

    //------------------------------------------------------------------------
    // APB

    assert property (@(posedge clk) disable iff (!rst_n) pready)
        else $error("pready is low");

    assert property (@(posedge clk) disable iff (!rst_n) pslverr |-> (psel && penable))
        else $error("pslverr outside an access cycle");

    //------------------------------------------------------------------------
    // Display and sound

    assert property (@(posedge clk) disable iff (!rst_n)
        (digit == '0) == (abcdefgh == SEG_BLANK))
        else $error("digit does not match the displayed pattern");

    assert property (@(posedge clk) disable iff (!rst_n) !synth_en |-> (sound == '0))
        else $error("sound active while the synth is disabled");

endmodule

bind note_lab_top note_lab_properties u_note_lab_properties (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .psel     ( psel     ),
    .penable  ( penable  ),
    .pready   ( pready   ),
    .pslverr  ( pslverr  ),
    .synth_en ( synth_en ),  // Internal wire of the top level
    .sound    ( sound    ),
    .abcdefgh ( abcdefgh ),
    .digit    ( digit    )
);

/* verification/tb_note_lab.sv */
`timescale 1ns/1ps

module tb_note_lab
    import note_pkg::*;
();

    localparam int   CLK_HALF       = 20;
    localparam int   DRIVE_DELAY    = 2;       // Inputs change after the rising edge
    localparam int   TIMEOUT_CYCLES = 20000;   // Tests need about 13000 cycles
    localparam int   FLIP_LIMIT     = 200;     // Longest wait for a sign change
    localparam mic_t MIC_HIGH       = 24'sh7FFFFF;
    localparam mic_t MIC_LOW        = mic_t'(24'h800000);

    // Nominal 48 kHz periods in ticks from C4 up
    localparam int NOMINAL_PERIOD [12] = '{
        184, 173, 164, 154, 146, 138, 130, 123, 116, 109, 103, 97
    };

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    mic_t        mic;
    sample_t     sound;
    seg_t        abcdefgh;
    logic [7:0]  digit;

    int          tone_period = 0;            // 0 means silence
    int          error_count = 0;
    logic [31:0] rand_state  = 32'he520d888;

    note_lab_top u_note_lab_top (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .psel     ( psel     ),
        .penable  ( penable  ),
        .pwrite   ( pwrite   ),
        .paddr    ( paddr    ),
        .pwdata   ( pwdata   ),
        .prdata   ( prdata   ),
        .pready   ( pready   ),
        .pslverr  ( pslverr  ),
        .mic      ( mic      ),
        .sound    ( sound    ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    //------------------------------------------------------------------------
    // Microphone square wave that starts with the high half

    initial begin : tone_gen
        int phase;
        int last_period;
        phase       = 0;
        last_period = 0;
        mic         = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (tone_period != last_period)
                phase = 0;                 // Restart on a new tone
            last_period = tone_period;
            if (tone_period == 0) begin
                mic = '0;
            end else begin
                mic   = (phase < tone_period / 2) ? MIC_HIGH : MIC_LOW;
                phase = (phase + 1 == tone_period) ? 0 : phase + 1;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_run();
    end

    //------------------------------------------------------------------------
    // Error handling and compare tasks

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic value_error(input string msg);
        error_count++;
        $display("FAILED at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_data(input string what, input apb_data_t got, input apb_data_t exp);
        if (got !== exp)
            value_error($sformatf("%s is 0x%08h, expected 0x%08h", what, got, exp));
    endtask

    task automatic check_seg(input string what, input seg_t got, input seg_t exp);
        if (got !== exp)
            value_error($sformatf("%s is %08b, expected %08b", what, got, exp));
    endtask

    task automatic check_sample(input string what, input sample_t got, input sample_t exp);
        if (got !== exp)
            value_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_period(input string what, input period_t got, input period_t exp);
        if (got !== exp)
            value_error($sformatf("%s is %0d ticks, expected %0d", what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            value_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    //------------------------------------------------------------------------
    // APB, tone and display helpers

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic err);
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b1;                    // Setup cycle
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;                    // Access cycle
        @(negedge clk);
        check_bit("pready on write", pready, 1'b1);
        check_bit("pslverr on write", pslverr, err);
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, input logic err);
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        @(negedge clk);
        check_bit("pready on read", pready, 1'b1);
        check_bit("pslverr on read", pslverr, err);
        data = prdata;                     // Valid in the access cycle
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_reg(input apb_addr_t addr, input apb_data_t exp);
        apb_data_t rd;
        apb_read(addr, rd, 1'b0);
        check_data($sformatf("register 0x%02h", addr), rd, exp);
    endtask

    task automatic play_tone(input int period);
        @(posedge clk);
        #1;                                // Ahead of the mic update
        tone_period = period;
    endtask

    task automatic check_digit(input seg_t shown);
        check_bit("digit 0", digit[0], shown != SEG_BLANK);
        check_bit("digits 7 to 1", |digit[7:1], 1'b0);
    endtask

    task automatic wait_display(input seg_t exp, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (abcdefgh !== exp && n < limit) begin
            @(negedge clk);
            n++;
        end
        check_seg("abcdefgh", abcdefgh, exp);
        check_digit(exp);
    endtask

    task automatic wait_sign_flip(output int cycles);
        logic start_sign;
        start_sign = sound[15];
        cycles     = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (sound[15] == start_sign && cycles <= FLIP_LIMIT);
    endtask

    //------------------------------------------------------------------------
    // Directed tests

    task automatic test_registers();
        apb_data_t rd;
        check_reg(ADDR_CTRL, '0);
        check_reg(ADDR_DIV, apb_data_t'(DIV_RESET));
        check_reg(ADDR_THRESH, apb_data_t'(THRESH_RESET));
        check_reg(ADDR_STATUS, '0);
        apb_write(ADDR_CTRL, 32'hFFFF_FFF7, 1'b0);
        check_reg(ADDR_CTRL, 32'h0000_0007);  // Enable and volume 3
        apb_write(ADDR_CTRL, '0, 1'b0);
        apb_write(ADDR_THRESH, 32'hABCD_1234, 1'b0);
        check_reg(ADDR_THRESH, 32'h0000_1234);
        apb_write(ADDR_THRESH, apb_data_t'(THRESH_RESET), 1'b0);
        apb_write(ADDR_DIV, 32'd5, 1'b0);
        check_reg(ADDR_DIV, 32'd5);
        apb_write(ADDR_DIV, '0, 1'b0);
        check_reg(ADDR_DIV, 32'd1);           // Zero acts as one
        apb_write(8'h10, 32'hF, 1'b1);
        apb_write(8'h02, 32'hF, 1'b1);
        apb_write(ADDR_STATUS, 32'hF, 1'b1);
        apb_read(8'h10, rd, 1'b1);
        check_reg(ADDR_CTRL, '0);
        check_reg(ADDR_DIV, 32'd1);
        check_reg(ADDR_THRESH, apb_data_t'(THRESH_RESET));
        check_reg(ADDR_STATUS, '0);
    endtask

    task automatic test_note(input int note, input logic [2:0] vol);
        int      p;
        int      n;
        sample_t amp;
        p   = NOMINAL_PERIOD[note];
        amp = 16'sd32767 >>> vol;
        $display("Note %0d, period %0d, volume %0d", note + 1, p, vol);
        play_tone(p);
        wait_display(NOTE_SEG[note], 3 * p + 3);
        check_reg(ADDR_STATUS, apb_data_t'(note + 1));
        apb_write(ADDR_CTRL, apb_data_t'({vol, 1'b1}), 1'b0);
        @(negedge clk);
        wait_sign_flip(n);                 // First flip may come early
        wait_sign_flip(n);
        check_period("sound half period", period_t'(n), period_t'(p / 2));
        check_sample("sound magnitude", sound[15] ? -sound : sound, amp);
        apb_write(ADDR_CTRL, apb_data_t'({vol, 1'b0}), 1'b0);
        repeat (50) begin
            @(negedge clk);
            check_sample("sound while disabled", sound, '0);
            check_seg("abcdefgh while disabled", abcdefgh, NOTE_SEG[note]);
        end
    endtask

    task automatic test_blanking();
        play_tone(60);                     // Shorter than any note
        wait_display(SEG_BLANK, 3 * 60 + 3);
        check_reg(ADDR_STATUS, '0);
        play_tone(NOMINAL_PERIOD[9]);
        wait_display(NOTE_SEG[9], 3 * NOMINAL_PERIOD[9] + 3);
        play_tone(0);
        repeat (int'(NOTE_TIMEOUT) + 10) @(negedge clk);
        check_seg("abcdefgh after silence", abcdefgh, SEG_BLANK);
        check_digit(SEG_BLANK);
        check_reg(ADDR_STATUS, '0);
    endtask

    //------------------------------------------------------------------------

    initial begin
        int          order [12];
        int          j;
        int          tmp;
        logic [31:0] rnd;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("pslverr after reset", pslverr, 1'b0);
        check_sample("sound after reset", sound, '0);
        check_seg("abcdefgh after reset", abcdefgh, SEG_BLANK);
        check_digit(SEG_BLANK);

        test_registers();                  // Leaves the divider at 1

        for (int i = 0; i < NUM_NOTES; i++)
            order[i] = i;
        for (int i = NUM_NOTES - 1; i > 0; i--) begin  // Shuffle the notes
            j        = int'(next_random() >> 16) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < NUM_NOTES; i++) begin
            rnd = next_random();
            test_note(order[i], rnd[20:18]);
        end

        test_blanking();

        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sim.f */
src/note_pkg.sv
src/lab_control.sv
src/note_recognizer.sv
src/note_synthesizer.sv
src/note_lab_top.sv
verification/note_lab_properties.sv
verification/tb_note_lab.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the note lab testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_note_lab -f sim.f --Mdir obj_dir -o tb_note_lab
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_note_lab 2>&1)
run_status=$?
echo "$output"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qxF "=== PASS ===" <<< "$output"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
